// File: all.f
+incdir+tb
logic/exec_pkg.sv
logic/alu_bitwise.sv
logic/alu_arith.sv
logic/mul_acc_unit.sv
logic/hilo_file.sv
logic/ex_stage.sv
logic/exec_top.sv
tb/tb_exec_top.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - logic/exec_pkg.sv
  - logic/alu_bitwise.sv
  - logic/alu_arith.sv
  - logic/mul_acc_unit.sv
  - logic/hilo_file.sv
  - logic/ex_stage.sv
  - logic/exec_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_exec_top.sv

// File: tb/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

logic [XLEN-1:0] model_hi;  // hi/lo as seen after each checked write
logic [XLEN-1:0] model_lo;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic accumulates(input alu_op_e op);
  return op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
endfunction

function automatic logic writes_gpr(input alu_op_e op);
  return !(op inside {OP_NOP, OP_MTHI, OP_MTLO, OP_MULT, OP_MULTU}) && !accumulates(op);
endfunction

function automatic int lead_count(input logic [31:0] v, input logic bit_val);
  int n;
  n = 0;
  while (n < 32 && v[31-n] == bit_val) n++;
  return n;
endfunction

// operands agree in sign but the result does not
function automatic logic signed_ovf(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  r = (op == OP_SUB) ? a - b : a + b;
  if (op == OP_ADD) return (a[31] == b[31]) && (r[31] != a[31]);
  if (op == OP_SUB) return (a[31] != b[31]) && (r[31] != a[31]);
  return 1'b0;
endfunction

function automatic logic [31:0] gpr_value(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
  logic [4:0] s;
  s = a[4:0];
  case (op)
    OP_OR:            return a | b;
    OP_AND:           return a & b;
    OP_NOR:           return ~(a | b);
    OP_XOR:           return a ^ b;
    OP_SLL:           return b << s;
    OP_SRL:           return b >> s;
    OP_SRA:           return (b >> s) | (~(32'hffff_ffff >> s) & {32{b[31]}});  // top s bits
    OP_MFHI:          return model_hi;
    OP_MFLO:          return model_lo;
    OP_ADD, OP_ADDU:  return a + b;
    OP_SUB, OP_SUBU:  return a - b;
    OP_SLT:           return {31'b0, $signed(a) < $signed(b)};
    OP_SLTU:          return {31'b0, a < b};
    OP_CLZ:           return lead_count(a, 1'b0);
    OP_CLO:           return lead_count(a, 1'b1);
    default:          return '0;
  endcase
endfunction

function automatic hilo_wr_t hilo_expect(input alu_op_e op, input logic [31:0] a,
                                         input logic [31:0] b);
  hilo_wr_t    w;
  logic [63:0] p;
  w = '0;
  if (op inside {OP_MULT, OP_MADD, OP_MSUB}) p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
  else p = {32'b0, a} * {32'b0, b};
  case (op)
    OP_MTHI:           {w.whi, w.val.pair.hi} = {1'b1, a};
    OP_MTLO:           {w.wlo, w.val.pair.lo} = {1'b1, a};
    OP_MULT, OP_MULTU: {w.whi, w.wlo, w.val.acc} = {2'b11, p};
    OP_MADD, OP_MADDU: {w.whi, w.wlo, w.val.acc} = {2'b11, {model_hi, model_lo} + p};
    OP_MSUB, OP_MSUBU: {w.whi, w.wlo, w.val.acc} = {2'b11, {model_hi, model_lo} - p};
    default: ;
  endcase
  return w;
endfunction

`endif

// File: tb/tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top import exec_pkg::*; ();

  logic     clk;
  logic     rst;
  ex_req_t  req_i;
  gpr_wr_t  gpr_o;
  hilo_wr_t hilo_o;
  logic     stall_o;

  logic [31:0] lfsr_q;
  int          checks;
  int          errors;
  int          timeouts;
  gpr_wr_t     exp_gpr_q[$];
  hilo_wr_t    exp_hilo_q[$];

  `include "exec_model.svh"

  exec_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .req_i   (req_i),
    .gpr_o   (gpr_o),
    .hilo_o  (hilo_o),
    .stall_o (stall_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_idle();
    compare("gpr_o.we", gpr_o.we, 1'b0);
    compare("hilo_o.whi", hilo_o.whi, 1'b0);
    compare("hilo_o.wlo", hilo_o.wlo, 1'b0);
  endtask

  // result of the request accepted one cycle ago, model follows the expected write
  task automatic check_outputs();
    gpr_wr_t  eg;
    hilo_wr_t eh;
    if (exp_gpr_q.size() == 0) return;
    eg = exp_gpr_q.pop_front();
    eh = exp_hilo_q.pop_front();
    compare("gpr_o.we", gpr_o.we, eg.we);
    if (eg.we) begin
      compare("gpr_o.waddr", gpr_o.waddr, eg.waddr);
      compare("gpr_o.wdata", gpr_o.wdata, eg.wdata);
    end
    compare("hilo_o.whi", hilo_o.whi, eh.whi);
    compare("hilo_o.wlo", hilo_o.wlo, eh.wlo);
    if (eh.whi) begin
      compare("hilo_o.val.hi", hilo_o.val.pair.hi, eh.val.pair.hi);
      model_hi = eh.val.pair.hi;
    end
    if (eh.wlo) begin
      compare("hilo_o.val.lo", hilo_o.val.pair.lo, eh.val.pair.lo);
      model_lo = eh.val.pair.lo;
    end
  endtask

  task automatic send_request();
    ex_req_t    req;
    gpr_wr_t    eg;
    hilo_wr_t   eh;
    logic [2:0] mode;
    int         stalls;
    req.valid = take_bits(3) != 0;  // mostly valid
    req.op    = alu_op_e'(take_bits(5) % 26);
    req.a     = take_bits(32);
    req.b     = take_bits(32);
    mode      = take_bits(3);
    if (mode == 0) req.a = req.a >> take_bits(5);  // long zero runs
    if (mode == 1) req.a = ~(~req.a >> take_bits(5));
    if (mode == 2) req.b = req.a;
    req.waddr = take_bits(5);
    req.we    = take_bits(2) != 0;
    req_i     = req;
    #1;
    stalls = 0;
    while (stall_o && stalls < 4) begin  // hold the accumulate request
      @(posedge clk);
      #2;
      check_idle();  // stall cycle leaves no write
      stalls++;
      #1;
    end
    if (stall_o) begin
      $display("Timeout, stall_o stayed high for 4 cycles at %0t", $time);
      timeouts++;
    end
    compare("stall_o cycles", stalls, (req.valid && accumulates(req.op)) ? 1 : 0);
    eg = '0;
    eh = '0;
    if (req.valid) begin
      eg.we    = req.we && writes_gpr(req.op) && !signed_ovf(req.op, req.a, req.b);
      eg.waddr = req.waddr;
      eg.wdata = gpr_value(req.op, req.a, req.b);
      eh       = hilo_expect(req.op, req.a, req.b);
    end
    exp_gpr_q.push_back(eg);
    exp_hilo_q.push_back(eh);
  endtask

  initial begin
    lfsr_q   = 32'h37bf;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    model_hi = '0;
    model_lo = '0;
    rst      = 1'b1;
    req_i    = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    #1;
    check_idle();
    compare("stall_o", stall_o, 1'b0);
    for (int i = 0; i < 2000 && timeouts == 0; i++) begin
      @(posedge clk);
      #2;
      check_outputs();
      send_request();
    end
    @(posedge clk);
    #2;
    check_outputs();  // last request
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  ex_req_t  req_i,
  output gpr_wr_t  gpr_o,
  output hilo_wr_t hilo_o,
  output logic     stall_o
);

  hilo_u cur_hilo;  // forwarded hi/lo pair

  ex_stage u_ex_stage (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req_i),
    .cur_hilo_i (cur_hilo),
    .gpr_o      (gpr_o),
    .hilo_o     (hilo_o),
    .stall_o    (stall_o)
  );

  // stage output is both the write port and the forwarding source
  hilo_file u_hilo_file (
    .clk   (clk),
    .rst   (rst),
    .wr_i  (hilo_o),
    .cur_o (cur_hilo)
  );

endmodule

`default_nettype wire

// File: logic/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  ex_req_t  req_i,
  input  hilo_u    cur_hilo_i,
  output gpr_wr_t  gpr_o,
  output hilo_wr_t hilo_o,
  output logic     stall_o
);

  alu_op_e         op;
  res_class_e      res_class;
  logic [XLEN-1:0] bit_res;
  logic [XLEN-1:0] arith_res;
  logic            ovf;
  logic [XLEN-1:0] wdata;
  gpr_wr_t         gpr_d;
  hilo_wr_t        hilo_d;

  assign op        = req_i.valid ? req_i.op : OP_NOP;  // bubble when idle
  assign res_class = op_class(op);

  alu_bitwise u_alu_bitwise (
    .op_i     (op),
    .a_i      (req_i.a),
    .b_i      (req_i.b),
    .result_o (bit_res)
  );

  alu_arith u_alu_arith (
    .op_i     (op),
    .a_i      (req_i.a),
    .b_i      (req_i.b),
    .result_o (arith_res),
    .ovf_o    (ovf)
  );

  mul_acc_unit u_mul_acc_unit (
    .clk     (clk),
    .rst     (rst),
    .op_i    (op),
    .a_i     (req_i.a),
    .b_i     (req_i.b),
    .cur_i   (cur_hilo_i),
    .hilo_o  (hilo_d),
    .stall_o (stall_o)
  );

  always_comb begin
    case (res_class)
      RES_LOGIC, RES_SHIFT: wdata = bit_res;
      RES_MOVE:  wdata = (op == OP_MFHI) ? cur_hilo_i.pair.hi : cur_hilo_i.pair.lo;
      RES_ARITH: wdata = arith_res;
      default:   wdata = '0;
    endcase
  end

  assign gpr_d.we    = req_i.we && (res_class != RES_NONE) && !ovf;  // overflow drops write
  assign gpr_d.waddr = req_i.waddr;
  assign gpr_d.wdata = wdata;

  // execute to memory register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      gpr_o  <= '0;
      hilo_o <= '0;
    end else if (stall_o) begin
      gpr_o  <= '0;
      hilo_o <= '0;
    end else begin
      gpr_o  <= gpr_d;
      hilo_o <= hilo_d;
    end
  end

  a_one_dest: assert property (@(posedge clk) disable iff (rst)
    !(gpr_o.we && (hilo_o.whi || hilo_o.wlo)));

endmodule

`default_nettype wire

// File: logic/hilo_file.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_file import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  hilo_wr_t wr_i,
  output hilo_u    cur_o
);

  logic [XLEN-1:0] hi_q;
  logic [XLEN-1:0] lo_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hi_q <= '0;
      lo_q <= '0;
    end else begin
      if (wr_i.whi) hi_q <= wr_i.val.pair.hi;
      if (wr_i.wlo) lo_q <= wr_i.val.pair.lo;
    end
  end

  // forward the write in flight, per half
  assign cur_o.pair.hi = wr_i.whi ? wr_i.val.pair.hi : hi_q;
  assign cur_o.pair.lo = wr_i.wlo ? wr_i.val.pair.lo : lo_q;

endmodule

`default_nettype wire

// File: logic/mul_acc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_acc_unit import exec_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  hilo_u           cur_i,
  output hilo_wr_t        hilo_o,
  output logic            stall_o
);

  logic                     phase_q;  // second cycle of an accumulate
  logic [2*XLEN-1:0]        prod_q;
  logic signed [2*XLEN-1:0] prod_s;
  logic [2*XLEN-1:0]        prod_u;
  logic [2*XLEN-1:0]        prod;
  logic                     is_signed;
  logic                     is_mac;

  assign is_mac    = is_mac_op(op_i);
  assign is_signed = (op_i == OP_MULT) || (op_i == OP_MADD) || (op_i == OP_MSUB);

  // kept apart so each multiply sees its own signedness
  assign prod_s = $signed(a_i) * $signed(b_i);
  assign prod_u = a_i * b_i;
  assign prod   = is_signed ? prod_s : prod_u;

  assign stall_o = is_mac && !phase_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase_q <= 1'b0;
    end else begin
      phase_q <= stall_o;
    end
  end

  always_ff @(posedge clk) begin
    if (stall_o) prod_q <= prod;  // product held for the accumulate cycle
  end

  always_comb begin
    hilo_o = '0;
    case (op_i)
      OP_MTHI: begin
        hilo_o.whi         = 1'b1;
        hilo_o.val.pair.hi = a_i;
      end
      OP_MTLO: begin
        hilo_o.wlo         = 1'b1;
        hilo_o.val.pair.lo = a_i;
      end
      OP_MULT, OP_MULTU: begin
        hilo_o.whi     = 1'b1;
        hilo_o.wlo     = 1'b1;
        hilo_o.val.acc = prod;
      end
      OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: begin
        if (phase_q) begin
          hilo_o.whi = 1'b1;
          hilo_o.wlo = 1'b1;
          // modular 64-bit sum, same for signed and unsigned
          if ((op_i == OP_MSUB) || (op_i == OP_MSUBU)) hilo_o.val.acc = cur_i.acc - prod_q;
          else hilo_o.val.acc = cur_i.acc + prod_q;
        end
      end
      default: ;
    endcase
  end

  // same request presented again after a stall
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    stall_o |=> $stable(op_i) && $stable(a_i) && $stable(b_i));

  // issuer must hold the accumulate request while in the second phase
  a_phase_mac: assert property (@(posedge clk) disable iff (rst) phase_q |-> is_mac);

endmodule

`default_nettype wire

// File: logic/alu_arith.sv
`timescale 1ns/1ps
`default_nettype none

module alu_arith import exec_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            ovf_o
);

  localparam int CNT_W = $clog2(XLEN + 1);

  logic [XLEN:0]      a_ext;
  logic [XLEN:0]      b_ext;
  logic [XLEN:0]      sum;
  logic               is_sub;
  logic [CNT_W-1:0]   lead_cnt;
  logic               lead_bit;
  logic               lead_stop;

  assign a_ext  = {a_i[XLEN-1], a_i};
  assign b_ext  = {b_i[XLEN-1], b_i};
  assign is_sub = (op_i == OP_SUB) || (op_i == OP_SUBU);
  assign sum    = is_sub ? a_ext - b_ext : a_ext + b_ext;

  // only the trapping forms report overflow
  assign ovf_o = ((op_i == OP_ADD) || (op_i == OP_SUB)) && (sum[XLEN] != sum[XLEN-1]);

  // leading zeros or ones of a, scanned from the msb
  always_comb begin
    lead_bit  = (op_i == OP_CLO);
    lead_cnt  = '0;
    lead_stop = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (!lead_stop && (a_i[i] == lead_bit)) begin
        lead_cnt = lead_cnt + 1'b1;
      end else begin
        lead_stop = 1'b1;
      end
    end
  end

  always_comb begin
    case (op_i)
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
        result_o = sum[XLEN-1:0];
      end
      OP_SLT:  result_o = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
      OP_SLTU: result_o = {{(XLEN-1){1'b0}}, (a_i < b_i)};
      OP_CLZ, OP_CLO: begin
        result_o = {{(XLEN-CNT_W){1'b0}}, lead_cnt};  // 0 to 32
      end
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/alu_bitwise.sv
`timescale 1ns/1ps
`default_nettype none

module alu_bitwise import exec_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o
);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = a_i[SHAMT_W-1:0];  // amount always from operand a

  always_comb begin
    case (op_i)
      OP_OR:   result_o = a_i | b_i;
      OP_AND:  result_o = a_i & b_i;
      OP_NOR:  result_o = ~(a_i | b_i);
      OP_XOR:  result_o = a_i ^ b_i;
      OP_SLL:  result_o = b_i << shamt;
      OP_SRL:  result_o = b_i >> shamt;
      // sign fill from b
      OP_SRA:  result_o = $signed(b_i) >>> shamt;
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;

  typedef enum logic [7:0] {
    OP_NOP, OP_OR, OP_AND, OP_NOR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA,
    OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
    OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO,
    OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU
  } alu_op_e;

  typedef enum logic [2:0] {
    RES_NONE, RES_LOGIC, RES_SHIFT, RES_MOVE, RES_ARITH
  } res_class_e;

  typedef struct packed {
    logic                  valid;
    alu_op_e               op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
  } ex_req_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } gpr_wr_t;

  typedef struct packed {
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } hilo_pair_t;

  // same 64 bits, seen as two registers or as one accumulator
  typedef union packed {
    hilo_pair_t        pair;
    logic [2*XLEN-1:0] acc;
  } hilo_u;

  typedef struct packed {
    logic  whi;
    logic  wlo;
    hilo_u val;
  } hilo_wr_t;

  // class of the general-register result, hi/lo writers give none
  function automatic res_class_e op_class(alu_op_e op);
    case (op)
      OP_OR, OP_AND, OP_NOR, OP_XOR: return RES_LOGIC;
      OP_SLL, OP_SRL, OP_SRA:        return RES_SHIFT;
      OP_MFHI, OP_MFLO:              return RES_MOVE;
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
      OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: return RES_ARITH;
      default:                       return RES_NONE;
    endcase
  endfunction

  function automatic logic is_mac_op(alu_op_e op);
    return (op == OP_MADD) || (op == OP_MADDU) || (op == OP_MSUB) || (op == OP_MSUBU);
  endfunction

endpackage

`default_nettype wire
